/* verilog/l1_cache_pkg.sv */
// Geometry, access size codes and controller state codes for the L1 cache
// Fixed at 64 lines of 16 bytes with 32-bit addresses
// Only aligned accesses are supported
package l1_cache_pkg;

  // ======================================================================
  // Address and line geometry
  // ======================================================================

  localparam int unsigned word_bits   = 32;
  localparam int unsigned tag_bits    = 22;
  localparam int unsigned index_bits  = 6;
  localparam int unsigned offset_bits = 4;

  localparam int unsigned line_words  = 4;
  localparam int unsigned line_bytes  = line_words * 4;
  localparam int unsigned num_lines   = 64;

  // ======================================================================
  // Access size codes on core_type and mem_type
  // ======================================================================

  localparam logic [1:0] size_byte = 2'b00;
  localparam logic [1:0] size_half = 2'b01;
  localparam logic [1:0] size_word = 2'b10;

  // ======================================================================
  // Controller states
  // ======================================================================

  localparam logic [2:0] st_idle   = 3'd0;
  localparam logic [2:0] st_lookup = 3'd1;
  localparam logic [2:0] st_refill = 3'd2;
  localparam logic [2:0] st_fill   = 3'd3;
  localparam logic [2:0] st_write  = 3'd4;

  // ======================================================================
  // Cache line
  // ======================================================================

  // Word view for refill and read select
  // Byte view for lane merge, byte 0 is the low byte of word 0
  typedef union packed {
    logic [line_words-1:0][word_bits-1:0] words;
    logic [line_bytes-1:0][7:0]           bytes;
  } cache_line_u;

endpackage

/* verilog/cache_store_if.sv */
// Lookup, fill and update signals between the cache controller and storage
// Read results appear one cycle after rd_en and hold until the next read
// Writes land at the clock edge where the enables are high
`timescale 1ns/1ps

interface cache_store_if;
  import l1_cache_pkg::*;

  // Lookup
  logic [index_bits-1:0] index;
  logic                  rd_en;

  // Fill and write-hit update
  logic [tag_bits-1:0]   tag_wdata;
  cache_line_u           line_wdata;
  logic [line_bytes-1:0] byte_we;
  logic                  tag_we;
  logic                  valid_set;

  // Registered read results
  logic [tag_bits-1:0]   tag_rdata;
  cache_line_u           line_rdata;
  logic                  valid_rdata;

  modport ctrl (
    output index, rd_en,
    output tag_wdata, line_wdata, byte_we, tag_we, valid_set,
    input  tag_rdata, line_rdata, valid_rdata
  );

  modport store (
    input  index, rd_en,
    input  tag_wdata, line_wdata, byte_we, tag_we, valid_set,
    output tag_rdata, line_rdata, valid_rdata
  );

endinterface

/* verilog/cache_store.sv */
// Tag array, data array and valid bits of the direct-mapped cache
// Arrays are inferred with a one-cycle registered read
// Tag and data contents are undefined until a line is filled
// Only the valid bits are cleared by reset
`timescale 1ns/1ps

module cache_store (
  input  logic         clk,
  input  logic         rst,
  cache_store_if.store store
);
  import l1_cache_pkg::*;

  logic [tag_bits-1:0]  tag_mem  [num_lines];
  cache_line_u          data_mem [num_lines];
  logic [num_lines-1:0] valid_q;

  // ======================================================================
  // Registered read port
  // ======================================================================

  // Tag and line hold their last value while rd_en is low
  always_ff @(posedge clk)
  begin
    if (store.rd_en)
    begin
      store.tag_rdata  <= tag_mem[store.index];
      store.line_rdata <= data_mem[store.index];
    end
  end

  // Valid result is cleared with the valid bits so a lookup after
  // reset never sees a stale hit
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      store.valid_rdata <= 1'b0;
    end
    else if (store.rd_en)
    begin
      store.valid_rdata <= valid_q[store.index];
    end
  end

  // ======================================================================
  // Write port
  // ======================================================================

  always_ff @(posedge clk)
  begin
    if (store.tag_we)
    begin
      tag_mem[store.index] <= store.tag_wdata;
    end
  end

  // Byte lanes are written independently for write hits
  always_ff @(posedge clk)
  begin
    for (int i = 0; i < line_bytes; i++)
    begin
      if (store.byte_we[i])
      begin
        data_mem[store.index].bytes[i] <= store.line_wdata.bytes[i];
      end
    end
  end

  // Valid bits only get set here, a line is never invalidated
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      valid_q <= '0;
    end
    else if (store.valid_set)
    begin
      valid_q[store.index] <= 1'b1;
    end
  end

endmodule

/* verilog/store_merge.sv */
// Byte-enable generation and line merge for write hits and refill beats
// Store data is lane aligned as on the memory bus, so a byte store to
// offset 1 carries its byte in data[15:8]
`timescale 1ns/1ps

module store_merge (
  input  l1_cache_pkg::cache_line_u                old_line,
  input  logic [l1_cache_pkg::word_bits-1:0]       data,
  input  logic [1:0]                               size,
  input  logic [l1_cache_pkg::offset_bits-1:0]     offset,
  input  logic [1:0]                               beat,
  input  logic                                     fill,
  output l1_cache_pkg::cache_line_u                new_line,
  output logic [l1_cache_pkg::line_bytes-1:0]      byte_we
);
  import l1_cache_pkg::*;

  cache_line_u           store_line;
  logic [line_bytes-1:0] lane_we;
  logic [1:0]            word_sel;

  assign word_sel = offset[offset_bits-1:2];

  // Same word in every slot, the lane enables pick what is used
  assign store_line.words = {line_words{data}};

  always_comb
  begin
    lane_we = '0;
    case (size)
      size_byte: lane_we[offset] = 1'b1;
      size_half: lane_we[{word_sel, offset[1], 1'b0} +: 2] = 2'b11;
      size_word: lane_we[{word_sel, 2'b00} +: 4] = 4'hf;
      default:   lane_we = '0;
    endcase
  end

  always_comb
  begin
    new_line = old_line;
    if (fill)
    begin
      // Refill beat replaces one whole word
      new_line.words[beat] = data;
      byte_we = '1;
    end
    else
    begin
      for (int i = 0; i < line_bytes; i++)
      begin
        if (lane_we[i])
        begin
          new_line.bytes[i] = store_line.bytes[i];
        end
      end
      byte_we = lane_we;
    end
  end

endmodule

/* verilog/cache_controller.sv */
// Lookup, refill and write-through control for the direct-mapped cache
// One core request in flight, core fields held stable until completion
// Write misses go to memory only and do not allocate a line
`timescale 1ns/1ps

module cache_controller (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic [l1_cache_pkg::word_bits-1:0]   core_addr,
  input  logic                                 core_req,
  input  logic                                 core_write,
  input  logic [l1_cache_pkg::word_bits-1:0]   core_in,
  input  logic [1:0]                           core_type,
  output logic [l1_cache_pkg::word_bits-1:0]   core_out,
  output logic                                 core_wait,
  input  logic [l1_cache_pkg::word_bits-1:0]   mem_out,
  input  logic                                 mem_wait,
  output logic                                 mem_req,
  output logic                                 mem_write,
  output logic [l1_cache_pkg::word_bits-1:0]   mem_addr,
  output logic [l1_cache_pkg::word_bits-1:0]   mem_in,
  output logic [1:0]                           mem_type,
  cache_store_if.ctrl                          store,
  output l1_cache_pkg::cache_line_u            merge_old_line,
  output logic [l1_cache_pkg::word_bits-1:0]   merge_data,
  output logic [1:0]                           merge_size,
  output logic [l1_cache_pkg::offset_bits-1:0] merge_offset,
  output logic [1:0]                           merge_beat,
  output logic                                 merge_fill,
  input  l1_cache_pkg::cache_line_u            merge_line,
  input  logic [l1_cache_pkg::line_bytes-1:0]  merge_byte_we
);
  import l1_cache_pkg::*;

  logic [2:0]             state_q;
  logic                   write_q;
  logic                   hit_q;
  logic [1:0]             beat_q;
  logic                   req_pending_q;
  logic [tag_bits-1:0]    tag_q;
  logic [index_bits-1:0]  index_q;
  logic [offset_bits-1:0] offset_q;
  logic [word_bits-1:0]   data_q;
  logic [1:0]             type_q;
  cache_line_u            line_q;
  logic [word_bits-1:0]   out_q;
  logic                   accept;
  logic                   hit;
  logic                   beat_done;
  logic [word_bits-1:0]   lookup_word;

  assign accept      = (state_q == st_idle) && core_req;
  assign hit         = store.valid_rdata && (store.tag_rdata == tag_q);
  assign beat_done   = (state_q == st_refill) && !req_pending_q && !mem_wait;
  assign lookup_word = store.line_rdata.words[offset_q[offset_bits-1:2]];

  // ======================================================================
  // State machine
  // ======================================================================

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state_q       <= st_idle;
      write_q       <= 1'b0;
      hit_q         <= 1'b0;
      beat_q        <= 2'd0;
      req_pending_q <= 1'b0;
    end
    else
    begin
      case (state_q)
        st_idle:
        begin
          if (core_req)
          begin
            state_q <= st_lookup;
            write_q <= core_write;
            beat_q  <= 2'd0;
          end
        end
        st_lookup:
        begin
          hit_q <= hit;
          if (write_q)
            state_q <= st_write;
          else if (!hit)
            state_q <= st_refill;
          else
            state_q <= st_idle;
        end
        st_refill:
        begin
          // Next beat is requested one cycle after the previous one ends
          if (req_pending_q)
          begin
            req_pending_q <= 1'b0;
          end
          else if (!mem_wait)
          begin
            beat_q <= beat_q + 2'd1;
            if (beat_q == 2'd3)
              state_q <= st_fill;
            else
              req_pending_q <= 1'b1;
          end
        end
        st_fill:  state_q <= st_idle;
        st_write:
        begin
          if (!mem_wait)
            state_q <= st_idle;
        end
        default:  state_q <= st_idle;
      endcase
    end
  end

  // Request fields, line buffer and returned word
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      tag_q    <= core_addr[word_bits-1 -: tag_bits];
      index_q  <= core_addr[offset_bits +: index_bits];
      offset_q <= core_addr[offset_bits-1:0];
      data_q   <= core_in;
      type_q   <= core_type;
    end
    if (state_q == st_lookup)
    begin
      line_q <= store.line_rdata;
      if (!write_q && hit)
        out_q <= lookup_word;
    end
    if (beat_done)
    begin
      line_q <= merge_line;
      if (beat_q == offset_q[offset_bits-1:2])
        out_q <= mem_out;
    end
  end

  // ======================================================================
  // Core and memory ports
  // ======================================================================

  always_comb
  begin
    case (state_q)
      st_idle:   core_wait = core_req;
      st_lookup: core_wait = write_q || !hit;
      st_fill:   core_wait = 1'b0;
      st_write:  core_wait = mem_wait;
      default:   core_wait = 1'b1;
    endcase
  end

  // Hit data bypasses out_q in the lookup cycle
  assign core_out  = (state_q == st_lookup) ? lookup_word : out_q;

  assign mem_req   = ((state_q == st_lookup) && (write_q || !hit))
                   || ((state_q == st_refill) && req_pending_q);
  assign mem_write = write_q && ((state_q == st_lookup) || (state_q == st_write));
  assign mem_addr  = write_q ? {tag_q, index_q, offset_q}
                             : {tag_q, index_q, beat_q, 2'b00};
  assign mem_in    = data_q;
  assign mem_type  = write_q ? type_q : size_word;

  // ======================================================================
  // Storage and merge unit
  // ======================================================================

  assign store.index      = (state_q == st_idle) ? core_addr[offset_bits +: index_bits]
                                                 : index_q;
  assign store.rd_en      = accept;
  assign store.tag_wdata  = tag_q;
  assign store.line_wdata = (state_q == st_fill) ? line_q : merge_line;
  assign store.byte_we    = ((state_q == st_fill)
                            || ((state_q == st_write) && hit_q && !mem_wait))
                            ? merge_byte_we : '0;
  assign store.tag_we     = (state_q == st_fill);
  assign store.valid_set  = (state_q == st_fill);

  assign merge_old_line = line_q;
  assign merge_data     = write_q ? data_q : mem_out;
  assign merge_size     = type_q;
  assign merge_offset   = offset_q;
  assign merge_beat     = beat_q;
  assign merge_fill     = (state_q == st_refill) || (state_q == st_fill);

endmodule

/* verilog/l1_cache.sv */
// Direct-mapped L1 cache with write-through and no write allocate
// Core and memory ports use a req/wait handshake, one request at a time
`timescale 1ns/1ps

module l1_cache (
  input  logic                               clk,
  input  logic                               rst,
  // Core side
  input  logic [l1_cache_pkg::word_bits-1:0] core_addr,
  input  logic                               core_req,
  input  logic                               core_write,
  input  logic [l1_cache_pkg::word_bits-1:0] core_in,
  input  logic [1:0]                         core_type,
  output logic [l1_cache_pkg::word_bits-1:0] core_out,
  output logic                               core_wait,
  // Memory side
  input  logic [l1_cache_pkg::word_bits-1:0] mem_out,
  input  logic                               mem_wait,
  output logic                               mem_req,
  output logic [l1_cache_pkg::word_bits-1:0] mem_addr,
  output logic                               mem_write,
  output logic [l1_cache_pkg::word_bits-1:0] mem_in,
  output logic [1:0]                         mem_type
);
  import l1_cache_pkg::*;

  cache_line_u           merge_old_line;
  cache_line_u           merge_line;
  logic [word_bits-1:0]  merge_data;
  logic [1:0]            merge_size;
  logic [offset_bits-1:0] merge_offset;
  logic [1:0]            merge_beat;
  logic                  merge_fill;
  logic [line_bytes-1:0] merge_byte_we;

  cache_store_if store_bus ();

  cache_controller i_cache_controller (
    .clk            (clk),
    .rst            (rst),
    .core_addr      (core_addr),
    .core_req       (core_req),
    .core_write     (core_write),
    .core_in        (core_in),
    .core_type      (core_type),
    .core_out       (core_out),
    .core_wait      (core_wait),
    .mem_out        (mem_out),
    .mem_wait       (mem_wait),
    .mem_req        (mem_req),
    .mem_write      (mem_write),
    .mem_addr       (mem_addr),
    .mem_in         (mem_in),
    .mem_type       (mem_type),
    .store          (store_bus.ctrl),
    .merge_old_line (merge_old_line),
    .merge_data     (merge_data),
    .merge_size     (merge_size),
    .merge_offset   (merge_offset),
    .merge_beat     (merge_beat),
    .merge_fill     (merge_fill),
    .merge_line     (merge_line),
    .merge_byte_we  (merge_byte_we)
  );

  store_merge i_store_merge (
    .old_line (merge_old_line),
    .data     (merge_data),
    .size     (merge_size),
    .offset   (merge_offset),
    .beat     (merge_beat),
    .fill     (merge_fill),
    .new_line (merge_line),
    .byte_we  (merge_byte_we)
  );

  cache_store i_cache_store (
    .clk   (clk),
    .rst   (rst),
    .store (store_bus.store)
  );

endmodule

/* test/l1_cache_assertions.sv */
// Handshake checks on the memory and core ports of the cache controller
// All checks are disabled while reset is high
`timescale 1ns/1ps

module l1_cache_assertions (
  input logic       clk,
  input logic       rst,
  input logic       mem_req,
  input logic       core_wait,
  input logic [2:0] state
);
  import l1_cache_pkg::*;

  int fail_count = 0;

  // Each memory transfer starts with a single-cycle pulse
  req_one_cycle: assert property (@(posedge clk) disable iff (rst) mem_req |=> !mem_req)
  else
  begin
    fail_count++;
    $error("mem_req stayed high for more than one cycle");
  end

  req_not_idle: assert property (@(posedge clk) disable iff (rst)
                                 (state == st_idle) |-> !mem_req)
  else
  begin
    fail_count++;
    $error("mem_req raised while the controller is idle");
  end

  // Core is stalled for the whole memory transfer
  wait_during_req: assert property (@(posedge clk) disable iff (rst) mem_req |-> core_wait)
  else
  begin
    fail_count++;
    $error("core_wait low while mem_req is high");
  end

endmodule

bind cache_controller l1_cache_assertions i_handshake_checks (
  .clk       (clk),
  .rst       (rst),
  .mem_req   (mem_req),
  .core_wait (core_wait),
  .state     (state_q)
);

/* test/tb_l1_cache.sv */
// Testbench for the direct-mapped L1 cache
// The memory model answers each request after 0 to 3 wait cycles
// Store data in the table is lane aligned, as the cache expects
`timescale 1ns/1ps

module tb_l1_cache;
  import l1_cache_pkg::*;

  typedef struct packed {
    logic        write;
    logic [31:0] addr;
    logic [1:0]  size;
    logic [31:0] data;
    logic        hit;
  } op_t;

  localparam int num_ops    = 16;
  localparam int max_cycles = 100;

  logic        clk;
  logic        rst;
  logic [31:0] core_addr;
  logic        core_req;
  logic        core_write;
  logic [31:0] core_in;
  logic [1:0]  core_type;
  logic [31:0] core_out;
  logic        core_wait;
  logic [31:0] mem_out;
  logic        mem_wait;
  logic        mem_req;
  logic [31:0] mem_addr;
  logic        mem_write;
  logic [31:0] mem_in;
  logic [1:0]  mem_type;

  op_t         ops [num_ops];
  logic [31:0] mem_words [logic [31:0]];
  logic [31:0] ref_words [logic [31:0]];
  logic [31:0] req_addr [$];
  logic [31:0] req_data [$];
  logic        req_write [$];
  logic [1:0]  req_type [$];
  logic [31:0] rand_state;

  l1_cache i_l1_cache (.*);

  // ====================================================================
  // Helpers and compare tasks
  // ====================================================================

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Memory model or expected contents, untouched words keep the fill pattern
  function automatic logic [31:0] word_at(input logic use_ref, input logic [31:0] addr);
    logic [31:0] key;
    key = {addr[31:2], 2'b00};
    if (use_ref && ref_words.exists(key))
      return ref_words[key];
    if (!use_ref && mem_words.exists(key))
      return mem_words[key];
    return key ^ 32'ha5a5_0000;
  endfunction

  function automatic logic [31:0] merge_lanes(input logic [31:0] old, input logic [31:0] data,
                                              input logic [1:0] size, input logic [1:0] lo);
    logic [3:0]  lanes;
    logic [31:0] res;
    case (size)
      size_byte: lanes = 4'b0001 << lo;
      size_half: lanes = lo[1] ? 4'b1100 : 4'b0011;
      default:   lanes = 4'b1111;
    endcase
    res = old;
    for (int i = 0; i < 4; i++)
    begin
      if (lanes[i])
        res[8*i +: 8] = data[8*i +: 8];
    end
    return res;
  endfunction

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  task automatic check_word(input string what, input logic [word_bits-1:0] got, exp);
    if (got !== exp)
      stop_run($sformatf("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp));
  endtask

  task automatic check_count(input string what, input int got, exp);
    if (got != exp)
      stop_run($sformatf("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, what, got, exp));
  endtask

  task automatic check_level(input string what, input logic got, exp);
    if (got !== exp)
      stop_run($sformatf("CHECK FAILED at %0t: %s is %b, expected %b", $time, what, got, exp));
  endtask

  task automatic check_port(input string what, input logic [word_bits-1:0] got_addr, exp_addr,
                            input logic [1:0] got_type, exp_type, input logic got_wr, exp_wr);
    if (got_addr !== exp_addr || got_type !== exp_type || got_wr !== exp_wr)
      stop_run($sformatf("CHECK FAILED at %0t: %s is %h/%b/%b, expected %h/%b/%b", $time,
                         what, got_addr, got_type, got_wr, exp_addr, exp_type, exp_wr));
  endtask

  // ====================================================================
  // Clock, memory model and assertion watch
  // ====================================================================

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic serve_request();
    logic [31:0] addr;
    logic [31:0] data;
    logic        write;
    logic [1:0]  size;
    logic [1:0]  delay;
    addr  = mem_addr;
    data  = mem_in;
    write = mem_write;
    size  = mem_type;
    req_addr.push_back(addr);
    req_data.push_back(data);
    req_write.push_back(write);
    req_type.push_back(size);
    rand_state = xorshift32(rand_state);
    delay      = rand_state[1:0];
    mem_wait   = 1'b1;
    repeat (delay) @(negedge clk);
    // Transfer ends at the edge after this one
    @(negedge clk);
    mem_wait = 1'b0;
    if (write)
      mem_words[{addr[31:2], 2'b00}] = merge_lanes(word_at(1'b0, addr), data, size, addr[1:0]);
    else
      mem_out = word_at(1'b0, addr);
  endtask

  initial
  begin
    mem_wait   = 1'b0;
    mem_out    = '0;
    rand_state = 32'h32dc_7be0;
    forever
    begin
      @(negedge clk);
      if (mem_req)
        serve_request();
    end
  end

  always @(negedge clk)
  begin
    if (i_l1_cache.i_cache_controller.i_handshake_checks.fail_count != 0)
      stop_run("A handshake assertion in the cache controller failed");
  end

  // ====================================================================
  // Stimulus
  // ====================================================================

  task automatic load_table();
    // write, address, size, data, expected hit
    ops[0]  = '{1'b0, 32'h0000_1044, size_word, 32'h0000_0000, 1'b0};
    ops[1]  = '{1'b0, 32'h0000_1040, size_word, 32'h0000_0000, 1'b1};
    ops[2]  = '{1'b0, 32'h0000_104c, size_word, 32'h0000_0000, 1'b1};
    ops[3]  = '{1'b1, 32'h0000_1045, size_byte, 32'h0000_5a00, 1'b1};
    ops[4]  = '{1'b1, 32'h0000_104a, size_half, 32'hbeef_0000, 1'b1};
    ops[5]  = '{1'b1, 32'h0000_1040, size_word, 32'h1234_5678, 1'b1};
    ops[6]  = '{1'b0, 32'h0000_1044, size_word, 32'h0000_0000, 1'b1};
    ops[7]  = '{1'b0, 32'h0000_1048, size_word, 32'h0000_0000, 1'b1};
    ops[8]  = '{1'b0, 32'h0000_1040, size_word, 32'h0000_0000, 1'b1};
    ops[9]  = '{1'b1, 32'h0000_2080, size_word, 32'hcafe_f00d, 1'b0};
    ops[10] = '{1'b1, 32'h0000_2087, size_byte, 32'h7700_0000, 1'b0};
    ops[11] = '{1'b0, 32'h0000_2084, size_word, 32'h0000_0000, 1'b0};
    ops[12] = '{1'b0, 32'h0000_2080, size_word, 32'h0000_0000, 1'b1};
    // Same index as line 0x1040 with another tag
    ops[13] = '{1'b0, 32'h0000_5044, size_word, 32'h0000_0000, 1'b0};
    ops[14] = '{1'b0, 32'h0000_1044, size_word, 32'h0000_0000, 1'b0};
    ops[15] = '{1'b0, 32'h0000_5048, size_word, 32'h0000_0000, 1'b0};
  endtask

  task automatic run_op(input op_t op);
    logic [31:0] base;
    logic [31:0] got;
    int          cycles;
    base = {op.addr[31:4], 4'h0};
    req_addr.delete();
    req_data.delete();
    req_write.delete();
    req_type.delete();
    @(negedge clk);
    core_req   = 1'b1;
    core_write = op.write;
    core_addr  = op.addr;
    core_in    = op.data;
    core_type  = op.size;
    // Acceptance edge, then count cycles up to completion
    @(posedge clk);
    cycles = 0;
    do
    begin
      @(negedge clk);
      #1;
      cycles++;
      if (cycles > max_cycles)
        stop_run($sformatf("Timeout: core_wait stayed high on access to %h", op.addr));
    end
    while (core_wait);
    got = core_out;
    @(posedge clk);
    @(negedge clk);
    core_req = 1'b0;
    if (op.write)
    begin
      check_count("memory requests on write", req_addr.size(), 1);
      check_port("write request", req_addr[0], op.addr, req_type[0], op.size,
                 req_write[0], 1'b1);
      check_word("mem_in on write", req_data[0], op.data);
      ref_words[{op.addr[31:2], 2'b00}] = merge_lanes(word_at(1'b1, op.addr), op.data,
                                                      op.size, op.addr[1:0]);
    end
    else
    begin
      check_word("core_out", got, word_at(1'b1, op.addr));
      if (op.hit)
      begin
        check_count("memory requests on read hit", req_addr.size(), 0);
        check_count("read hit latency", cycles + 1, 2);
      end
      else
      begin
        check_count("memory reads on miss", req_addr.size(), line_words);
        for (int i = 0; i < line_words; i++)
          check_port("refill request", req_addr[i], base + 4 * i, req_type[i], size_word,
                     req_write[i], 1'b0);
      end
    end
  endtask

  initial
  begin
    rst        = 1'b1;
    core_req   = 1'b0;
    core_write = 1'b0;
    core_addr  = '0;
    core_in    = '0;
    core_type  = size_word;
    load_table();
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    // Quiet ports until the first request
    for (int i = 0; i < 4; i++)
    begin
      @(negedge clk);
      #1;
      check_level("core_wait after reset", core_wait, 1'b0);
      check_level("mem_req after reset", mem_req, 1'b0);
    end
    for (int i = 0; i < num_ops; i++)
      run_op(ops[i]);
    $display("TESTS PASSED");
    $finish;
  end

endmodule

/* src.f */
verilog/l1_cache_pkg.sv
verilog/cache_store_if.sv
verilog/cache_store.sv
verilog/store_merge.sv
verilog/cache_controller.sv
verilog/l1_cache.sv
test/l1_cache_assertions.sv
test/tb_l1_cache.sv

/* Makefile */
# Verilator build and run of the L1 cache testbench
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_l1_cache
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= TESTS PASSED
VFLAGS    ?= --binary --timing --assert
# Keep running after an assertion error so the testbench ends the run
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
